// ==== rtl/rv_exec_pkg.sv ====
package rv_exec_pkg;

   // decoded operation, one value per supported instruction
   typedef enum logic [5:0] {
      // upper immediates and jumps
      op_lui, op_auipc,
      op_jal, op_jalr,
      // branches
      op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
      // loads and stores
      op_lb, op_lh, op_lw, op_lbu, op_lhu,
      op_sb, op_sh, op_sw,
      // immediate alu forms
      op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
      op_slli, op_srli, op_srai,
      // register alu forms
      op_add, op_sub, op_sll, op_slt, op_sltu,
      op_xor, op_srl, op_sra, op_or, op_and,
      // float memory
      op_flw, op_fsw,
      // float bit operations
      op_fsgnj, op_fsgnjn, op_fsgnjx,
      op_feq, op_flt, op_fle,
      op_fmvxw, op_fmvwx,
      op_illegal
   } op_t;

   ////////////////////
   // major opcodes
   ////////////////////

   localparam logic [6:0] opc_lui      = 7'b0110111;
   localparam logic [6:0] opc_auipc    = 7'b0010111;
   localparam logic [6:0] opc_jal      = 7'b1101111;
   localparam logic [6:0] opc_jalr     = 7'b1100111;
   localparam logic [6:0] opc_branch   = 7'b1100011;
   localparam logic [6:0] opc_load     = 7'b0000011;
   localparam logic [6:0] opc_store    = 7'b0100011;
   localparam logic [6:0] opc_op_imm   = 7'b0010011;
   localparam logic [6:0] opc_op       = 7'b0110011;

   // single precision float
   localparam logic [6:0] opc_load_fp  = 7'b0000111;
   localparam logic [6:0] opc_store_fp = 7'b0100111;
   localparam logic [6:0] opc_op_fp    = 7'b1010011;

endpackage

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder import rv_exec_pkg::*; (
   input  logic [31:0] instr_word,
   output op_t         op,
   output logic [4:0]  rd,
   output logic [31:0] imm
);

   localparam logic [6:0] f7_base  = 7'b0000000;
   localparam logic [6:0] f7_alt   = 7'b0100000;
   localparam logic [6:0] f7_fsgnj = 7'b0010000;
   localparam logic [6:0] f7_fcmp  = 7'b1010000;
   localparam logic [6:0] f7_fmvxw = 7'b1110000;
   localparam logic [6:0] f7_fmvwx = 7'b1111000;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic [4:0] rs2_field;

   assign opcode    = instr_word[6:0];
   assign funct3    = instr_word[14:12];
   assign funct7    = instr_word[31:25];
   assign rs2_field = instr_word[24:20];
   assign rd        = instr_word[11:7];

   ////////////////////
   // operation
   ////////////////////

   always_comb begin
      op = op_illegal;
      case (opcode)
         opc_lui:   op = op_lui;
         opc_auipc: op = op_auipc;
         opc_jal:   op = op_jal;
         opc_jalr:  if (funct3 == 3'b000) op = op_jalr;
         opc_branch:
            case (funct3)
               3'b000:  op = op_beq;
               3'b001:  op = op_bne;
               3'b100:  op = op_blt;
               3'b101:  op = op_bge;
               3'b110:  op = op_bltu;
               3'b111:  op = op_bgeu;
               default: op = op_illegal;
            endcase
         opc_load:
            case (funct3)
               3'b000:  op = op_lb;
               3'b001:  op = op_lh;
               3'b010:  op = op_lw;
               3'b100:  op = op_lbu;
               3'b101:  op = op_lhu;
               default: op = op_illegal;
            endcase
         opc_store:
            case (funct3)
               3'b000:  op = op_sb;
               3'b001:  op = op_sh;
               3'b010:  op = op_sw;
               default: op = op_illegal;
            endcase
         opc_op_imm:
            case (funct3)
               3'b000: op = op_addi;
               3'b010: op = op_slti;
               3'b011: op = op_sltiu;
               3'b100: op = op_xori;
               3'b110: op = op_ori;
               3'b111: op = op_andi;
               // shifts carry funct7 in the upper immediate bits
               3'b001: if (funct7 == f7_base) op = op_slli;
               default: begin
                  if (funct7 == f7_base) op = op_srli;
                  else if (funct7 == f7_alt) op = op_srai;
               end
            endcase
         opc_op:
            if (funct7 == f7_base) begin
               case (funct3)
                  3'b000: op = op_add;
                  3'b001: op = op_sll;
                  3'b010: op = op_slt;
                  3'b011: op = op_sltu;
                  3'b100: op = op_xor;
                  3'b101: op = op_srl;
                  3'b110: op = op_or;
                  default: op = op_and;
               endcase
            end else if (funct7 == f7_alt) begin
               if (funct3 == 3'b000) op = op_sub;
               else if (funct3 == 3'b101) op = op_sra;
            end
         opc_load_fp:  if (funct3 == 3'b010) op = op_flw;
         opc_store_fp: if (funct3 == 3'b010) op = op_fsw;
         opc_op_fp:
            case (funct7)
               f7_fsgnj:
                  if (funct3 == 3'b000) op = op_fsgnj;
                  else if (funct3 == 3'b001) op = op_fsgnjn;
                  else if (funct3 == 3'b010) op = op_fsgnjx;
               f7_fcmp:
                  if (funct3 == 3'b010) op = op_feq;
                  else if (funct3 == 3'b001) op = op_flt;
                  else if (funct3 == 3'b000) op = op_fle;
               f7_fmvxw: if (rs2_field == 5'd0 && funct3 == 3'b000) op = op_fmvxw;
               f7_fmvwx: if (rs2_field == 5'd0 && funct3 == 3'b000) op = op_fmvwx;
               default: op = op_illegal;
            endcase
         default: op = op_illegal;
      endcase
   end

   ////////////////////
   // immediate
   ////////////////////

   always_comb begin
      case (opcode)
         opc_op_imm, opc_load, opc_load_fp, opc_jalr:
            imm = {{20{instr_word[31]}}, instr_word[31:20]};
         opc_store, opc_store_fp:
            imm = {{20{instr_word[31]}}, instr_word[31:25], instr_word[11:7]};
         opc_branch:
            imm = {{19{instr_word[31]}}, instr_word[31], instr_word[7],
                   instr_word[30:25], instr_word[11:8], 1'b0};
         opc_lui, opc_auipc:
            imm = {instr_word[31:12], 12'b0};
         opc_jal:
            imm = {{11{instr_word[31]}}, instr_word[31], instr_word[19:12],
                   instr_word[20], instr_word[30:21], 1'b0};
         default: imm = 32'd0;
      endcase
   end

endmodule

// ==== rtl/int_alu.sv ====
`timescale 1ns/10ps

module int_alu import rv_exec_pkg::*; (
   input  op_t         op,
   input  logic [31:0] pc,
   input  logic [31:0] rs1_v,
   input  logic [31:0] rs2_v,
   input  logic [31:0] imm,
   output logic [31:0] alu_result
);

   logic        imm_form;
   logic [31:0] operand_b;
   logic [4:0]  shamt;
   logic        lt_s;
   logic        lt_u;
   logic        eq;

   // immediate forms take imm as second operand
   assign imm_form = op inside {op_addi, op_slti, op_sltiu, op_xori, op_ori,
                                op_andi, op_slli, op_srli, op_srai};
   assign operand_b = imm_form ? imm : rs2_v;
   assign shamt     = operand_b[4:0];

   assign lt_s = $signed(rs1_v) < $signed(operand_b);
   assign lt_u = rs1_v < operand_b;
   assign eq   = rs1_v == operand_b;

   always_comb begin
      case (op)
         op_lui:   alu_result = imm;
         op_auipc: alu_result = pc + imm;

         // link value
         op_jal, op_jalr: alu_result = pc + 32'd4;

         // branch outcome as 0 or 1
         op_beq:  alu_result = {31'd0, eq};
         op_bne:  alu_result = {31'd0, !eq};
         op_blt:  alu_result = {31'd0, lt_s};
         op_bge:  alu_result = {31'd0, !lt_s};
         op_bltu: alu_result = {31'd0, lt_u};
         op_bgeu: alu_result = {31'd0, !lt_u};

         // effective address
         op_lb, op_lh, op_lw, op_lbu, op_lhu,
         op_sb, op_sh, op_sw, op_flw, op_fsw:
            alu_result = rs1_v + imm;

         op_addi, op_add:   alu_result = rs1_v + operand_b;
         op_sub:            alu_result = rs1_v - operand_b;
         op_slti, op_slt:   alu_result = {31'd0, lt_s};
         op_sltiu, op_sltu: alu_result = {31'd0, lt_u};
         op_xori, op_xor:   alu_result = rs1_v ^ operand_b;
         op_ori, op_or:     alu_result = rs1_v | operand_b;
         op_andi, op_and:   alu_result = rs1_v & operand_b;
         op_slli, op_sll:   alu_result = rs1_v << shamt;
         op_srli, op_srl:   alu_result = rs1_v >> shamt;
         op_srai, op_sra:   alu_result = $unsigned($signed(rs1_v) >>> shamt);
         default:           alu_result = 32'd0;
      endcase
   end

endmodule

// ==== rtl/float_unit.sv ====
`timescale 1ns/10ps

module float_unit import rv_exec_pkg::*; (
   input  op_t         op,
   input  logic [31:0] rs1_v,
   input  logic [31:0] frs1_v,
   input  logic [31:0] frs2_v,
   output logic [31:0] fpu_result
);

   logic        sign_a;
   logic        sign_b;
   logic [30:0] mag_a;
   logic [30:0] mag_b;
   logic        nan_a;
   logic        nan_b;
   logic        any_nan;
   logic        both_zero;
   logic        f_eq;
   logic        f_lt;

   assign sign_a = frs1_v[31];
   assign sign_b = frs2_v[31];
   assign mag_a  = frs1_v[30:0];
   assign mag_b  = frs2_v[30:0];

   // exponent all ones with nonzero fraction
   assign nan_a   = (frs1_v[30:23] == 8'hff) && (frs1_v[22:0] != 23'd0);
   assign nan_b   = (frs2_v[30:23] == 8'hff) && (frs2_v[22:0] != 23'd0);
   assign any_nan = nan_a || nan_b;

   // +0 and -0 compare equal
   assign both_zero = (mag_a == 31'd0) && (mag_b == 31'd0);

   ////////////////////
   // compare
   ////////////////////

   assign f_eq = !any_nan && (both_zero || frs1_v == frs2_v);

   always_comb begin
      if (any_nan || both_zero) begin
         f_lt = 1'b0;
      end else if (sign_a != sign_b) begin
         f_lt = sign_a;
      end else if (!sign_a) begin
         f_lt = mag_a < mag_b;
      end else begin
         // both negative, larger magnitude is smaller
         f_lt = mag_a > mag_b;
      end
   end

   ////////////////////
   // result
   ////////////////////

   always_comb begin
      case (op)
         op_fsgnj:  fpu_result = {sign_b, mag_a};
         op_fsgnjn: fpu_result = {!sign_b, mag_a};
         op_fsgnjx: fpu_result = {sign_a ^ sign_b, mag_a};
         op_feq:    fpu_result = {31'd0, f_eq};
         op_flt:    fpu_result = {31'd0, f_lt};
         op_fle:    fpu_result = {31'd0, f_lt || f_eq};
         // raw moves between the register files
         op_fmvxw:  fpu_result = frs1_v;
         op_fmvwx:  fpu_result = rs1_v;
         default:   fpu_result = 32'd0;
      endcase
   end

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage import rv_exec_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        issue,
   input  op_t         op,
   input  logic [4:0]  rd,
   input  logic [31:0] imm,
   input  logic [31:0] pc,
   input  logic [31:0] rs1_v,
   input  logic [31:0] rs2_v,
   input  logic [31:0] frs1_v,
   input  logic [31:0] frs2_v,
   output logic        done,
   output logic [31:0] result,
   output logic        mem_read,
   output logic        mem_write,
   output logic        reg_write,
   output logic        freg_write,
   output logic [4:0]  write_dest,
   output logic        jump,
   output logic [31:0] jump_dest,
   output logic        illegal
);

   logic [31:0] alu_result;
   logic [31:0] fpu_result;

   int_alu u_int_alu (
      .op         (op),
      .pc         (pc),
      .rs1_v      (rs1_v),
      .rs2_v      (rs2_v),
      .imm        (imm),
      .alu_result (alu_result)
   );

   float_unit u_float_unit (
      .op         (op),
      .rs1_v      (rs1_v),
      .frs1_v     (frs1_v),
      .frs2_v     (frs2_v),
      .fpu_result (fpu_result)
   );

   ////////////////////
   // classify
   ////////////////////

   logic is_load;
   logic is_store;
   logic is_branch;
   logic is_freg_dest;
   logic is_fpu_result;
   logic is_illegal;
   logic jump_next;
   logic [31:0] jump_dest_next;
   logic [31:0] result_next;

   assign is_load       = op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu, op_flw};
   assign is_store      = op inside {op_sb, op_sh, op_sw, op_fsw};
   assign is_branch     = op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
   assign is_freg_dest  = op inside {op_flw, op_fsgnj, op_fsgnjn, op_fsgnjx, op_fmvwx};
   assign is_fpu_result = op inside {op_fsgnj, op_fsgnjn, op_fsgnjx, op_feq, op_flt,
                                     op_fle, op_fmvxw, op_fmvwx};
   assign is_illegal    = op == op_illegal;

   // taken branch reported by the alu as 1
   assign jump_next = (op == op_jal) || (op == op_jalr) ||
                      (is_branch && alu_result == 32'd1);

   always_comb begin
      if (op == op_jal || is_branch)
         jump_dest_next = pc + imm;
      else if (op == op_jalr)
         jump_dest_next = (rs1_v + imm) & ~32'd1;
      else
         jump_dest_next = 32'd0;
   end

   assign result_next = is_illegal    ? 32'd0 :
                        is_fpu_result ? fpu_result : alu_result;

   ////////////////////
   // output register
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         done       <= 1'b0;
         mem_read   <= 1'b0;
         mem_write  <= 1'b0;
         reg_write  <= 1'b0;
         freg_write <= 1'b0;
         jump       <= 1'b0;
         illegal    <= 1'b0;
      end else begin
         done       <= issue;
         mem_read   <= issue && is_load;
         mem_write  <= issue && is_store;
         reg_write  <= issue && !(is_illegal || is_branch || is_store || is_freg_dest);
         freg_write <= issue && is_freg_dest;
         jump       <= issue && jump_next;
         illegal    <= issue && is_illegal;
      end
   end

   // payload held between issues
   always_ff @(posedge clk) begin
      if (issue) begin
         result     <= result_next;
         write_dest <= rd;
         jump_dest  <= jump_dest_next;
      end
   end

endmodule

// ==== rtl/exec_top.sv ====
`timescale 1ns/10ps

module exec_top import rv_exec_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        issue,
   input  logic [31:0] instr_word,
   input  logic [31:0] pc,
   input  logic [31:0] rs1_v,
   input  logic [31:0] rs2_v,
   input  logic [31:0] frs1_v,
   input  logic [31:0] frs2_v,
   output logic        done,
   output logic [31:0] result,
   output logic        mem_read,
   output logic        mem_write,
   output logic        reg_write,
   output logic        freg_write,
   output logic [4:0]  write_dest,
   output logic        jump,
   output logic [31:0] jump_dest,
   output logic        illegal
);

   op_t         op;
   logic [4:0]  rd;
   logic [31:0] imm;

   instr_decoder u_instr_decoder (
      .instr_word (instr_word),
      .op         (op),
      .rd         (rd),
      .imm        (imm)
   );

   execute_stage u_execute_stage (
      .clk        (clk),
      .reset      (reset),
      .issue      (issue),
      .op         (op),
      .rd         (rd),
      .imm        (imm),
      .pc         (pc),
      .rs1_v      (rs1_v),
      .rs2_v      (rs2_v),
      .frs1_v     (frs1_v),
      .frs2_v     (frs2_v),
      .done       (done),
      .result     (result),
      .mem_read   (mem_read),
      .mem_write  (mem_write),
      .reg_write  (reg_write),
      .freg_write (freg_write),
      .write_dest (write_dest),
      .jump       (jump),
      .jump_dest  (jump_dest),
      .illegal    (illegal)
   );

endmodule

// ==== sim/exec_assertions.sv ====
`timescale 1ns/10ps

module exec_assertions (
   input logic clk,
   input logic reset,
   input logic issue,
   input logic done,
   input logic mem_read,
   input logic mem_write,
   input logic reg_write,
   input logic freg_write,
   input logic jump,
   input logic illegal
);

   // one cycle from issue to done
   done_follows_issue: assert property (@(posedge clk) disable iff (reset)
      done == $past(issue))
      else $error("done is not issue delayed by one cycle");

   mem_flags_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(mem_read && mem_write))
      else $error("mem_read and mem_write high together");

   reg_flags_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(reg_write && freg_write))
      else $error("reg_write and freg_write high together");

   enables_need_done: assert property (@(posedge clk) disable iff (reset)
      (mem_read || mem_write || reg_write || freg_write || jump || illegal) |-> done)
      else $error("enable high outside a done cycle");

endmodule

bind execute_stage exec_assertions u_exec_assertions (
   .clk        (clk),
   .reset      (reset),
   .issue      (issue),
   .done       (done),
   .mem_read   (mem_read),
   .mem_write  (mem_write),
   .reg_write  (reg_write),
   .freg_write (freg_write),
   .jump       (jump),
   .illegal    (illegal)
);

// ==== sim/exec_tb.sv ====
`timescale 1ns/10ps

module exec_tb import rv_exec_pkg::*; ();

   localparam int unsigned num_instr   = 2000;
   localparam int unsigned cycle_limit = 10 + num_instr * 5 + 50;

   typedef struct packed {
      op_t         op;
      logic [31:0] result;
      logic        mem_read;
      logic        mem_write;
      logic        reg_write;
      logic        freg_write;
      logic [4:0]  write_dest;
      logic        jump;
      logic [31:0] jump_dest;
      logic        illegal;
      logic [31:0] due_cycle;
   } expect_t;

   logic        clk = 1'b0;
   logic        reset;
   logic        issue;
   logic [31:0] instr_word;
   logic [31:0] pc;
   logic [31:0] rs1_v;
   logic [31:0] rs2_v;
   logic [31:0] frs1_v;
   logic [31:0] frs2_v;
   logic        done;
   logic [31:0] result;
   logic        mem_read;
   logic        mem_write;
   logic        reg_write;
   logic        freg_write;
   logic [4:0]  write_dest;
   logic        jump;
   logic [31:0] jump_dest;
   logic        illegal;

   expect_t     pending[$];
   expect_t     got;
   op_t         got_op;
   string       tag;
   int unsigned cycles = 0;
   int unsigned checked = 0;

   exec_top u_exec_top (
      .clk        (clk),
      .reset      (reset),
      .issue      (issue),
      .instr_word (instr_word),
      .pc         (pc),
      .rs1_v      (rs1_v),
      .rs2_v      (rs2_v),
      .frs1_v     (frs1_v),
      .frs2_v     (frs2_v),
      .done       (done),
      .result     (result),
      .mem_read   (mem_read),
      .mem_write  (mem_write),
      .reg_write  (reg_write),
      .freg_write (freg_write),
      .write_dest (write_dest),
      .jump       (jump),
      .jump_dest  (jump_dest),
      .illegal    (illegal)
   );

   always #10 clk = ~clk;

   ////////////////////
   // encoding table
   ////////////////////

   function automatic logic [6:0] opcode_of(input op_t o);
      case (o)
         op_lui:   return opc_lui;
         op_auipc: return opc_auipc;
         op_jal:   return opc_jal;
         op_jalr:  return opc_jalr;
         op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: return opc_branch;
         op_lb, op_lh, op_lw, op_lbu, op_lhu: return opc_load;
         op_sb, op_sh, op_sw: return opc_store;
         op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
         op_slli, op_srli, op_srai: return opc_op_imm;
         op_add, op_sub, op_sll, op_slt, op_sltu,
         op_xor, op_srl, op_sra, op_or, op_and: return opc_op;
         op_flw:   return opc_load_fp;
         op_fsw:   return opc_store_fp;
         default:  return opc_op_fp;
      endcase
   endfunction

   function automatic logic [2:0] funct3_of(input op_t o);
      case (o)
         op_bne, op_lh, op_sh, op_slli, op_sll, op_fsgnjn, op_flt: return 3'b001;
         op_lw, op_sw, op_slti, op_slt, op_flw, op_fsw, op_fsgnjx, op_feq: return 3'b010;
         op_sltiu, op_sltu: return 3'b011;
         op_blt, op_lbu, op_xori, op_xor: return 3'b100;
         op_bge, op_lhu, op_srli, op_srai, op_srl, op_sra: return 3'b101;
         op_bltu, op_ori, op_or: return 3'b110;
         op_bgeu, op_andi, op_and: return 3'b111;
         default: return 3'b000;
      endcase
   endfunction

   function automatic logic [6:0] funct7_of(input op_t o);
      case (o)
         op_srai, op_sub, op_sra: return 7'b0100000;
         op_fsgnj, op_fsgnjn, op_fsgnjx: return 7'b0010000;
         op_feq, op_flt, op_fle: return 7'b1010000;
         op_fmvxw: return 7'b1110000;
         op_fmvwx: return 7'b1111000;
         default: return 7'b0000000;
      endcase
   endfunction

   function automatic logic checks_funct3(input op_t o);
      return !(o inside {op_lui, op_auipc, op_jal});
   endfunction

   function automatic logic checks_funct7(input op_t o);
      return o inside {op_slli, op_srli, op_srai, op_add, op_sub, op_sll, op_slt, op_sltu,
                       op_xor, op_srl, op_sra, op_or, op_and, op_fsgnj, op_fsgnjn,
                       op_fsgnjx, op_feq, op_flt, op_fle, op_fmvxw, op_fmvwx};
   endfunction

   function automatic logic needs_rs2_zero(input op_t o);
      return o inside {op_fmvxw, op_fmvwx};
   endfunction

   // first table entry whose fixed fields all match, else illegal
   function automatic op_t decode_word(input logic [31:0] w);
      op_t o;
      op_t found;
      int  i;
      found = op_illegal;
      for (i = 0; i < int'(op_illegal); i++) begin
         o = op_t'(i[5:0]);
         if (w[6:0] == opcode_of(o) &&
             (!checks_funct3(o) || w[14:12] == funct3_of(o)) &&
             (!checks_funct7(o) || w[31:25] == funct7_of(o)) &&
             (!needs_rs2_zero(o) || w[24:20] == 5'd0))
            found = o;
      end
      return found;
   endfunction

   function automatic logic [31:0] encode_word(input op_t o, input logic [31:0] fill);
      logic [31:0] w;
      w = fill;
      w[6:0] = opcode_of(o);
      if (checks_funct3(o))
         w[14:12] = funct3_of(o);
      if (checks_funct7(o))
         w[31:25] = funct7_of(o);
      if (needs_rs2_zero(o))
         w[24:20] = 5'd0;
      return w;
   endfunction

   // mostly random, with signed zeros, nans and infinities mixed in
   function automatic logic [31:0] float_value();
      logic [31:0] r;
      r = $urandom;
      case ($urandom_range(0, 5))
         0: return {r[31], 31'd0};
         1: return {r[31], 8'hff, r[22:1], 1'b1};
         2: return {r[31], 8'hff, 23'd0};
         default: return r;
      endcase
   endfunction

   ////////////////////
   // reference model
   ////////////////////

   function automatic expect_t predict(input logic [31:0] w, input logic [31:0] p,
                                       input logic [31:0] a, input logic [31:0] b,
                                       input logic [31:0] fa, input logic [31:0] fb);
      expect_t            e;
      op_t                o;
      logic [31:0]        imm;
      logic [31:0]        opnd;
      logic [31:0]        alu;
      logic [31:0]        fpu;
      logic               is_branch;
      logic               nan;
      logic signed [32:0] key_a;
      logic signed [32:0] key_b;

      o = decode_word(w);
      e = '0;
      e.op = o;
      is_branch = o inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};

      if (o inside {op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi, op_slli,
                    op_srli, op_srai, op_lb, op_lh, op_lw, op_lbu, op_lhu, op_flw, op_jalr})
         imm = {{20{w[31]}}, w[31:20]};
      else if (o inside {op_sb, op_sh, op_sw, op_fsw})
         imm = {{20{w[31]}}, w[31:25], w[11:7]};
      else if (is_branch)
         imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      else if (o inside {op_lui, op_auipc})
         imm = {w[31:12], 12'd0};
      else if (o == op_jal)
         imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      else
         imm = 32'd0;

      opnd = (o inside {op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
                        op_slli, op_srli, op_srai}) ? imm : b;
      case (o)
         op_lui:            alu = imm;
         op_auipc:          alu = p + imm;
         op_jal, op_jalr:   alu = p + 32'd4;
         op_beq:            alu = {31'd0, a == b};
         op_bne:            alu = {31'd0, a != b};
         op_blt:            alu = {31'd0, $signed(a) < $signed(b)};
         op_bge:            alu = {31'd0, $signed(a) >= $signed(b)};
         op_bltu:           alu = {31'd0, a < b};
         op_bgeu:           alu = {31'd0, a >= b};
         op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw, op_flw, op_fsw:
            alu = a + imm;
         op_addi, op_add:   alu = a + opnd;
         op_sub:            alu = a - opnd;
         op_slti, op_slt:   alu = {31'd0, $signed(a) < $signed(opnd)};
         op_sltiu, op_sltu: alu = {31'd0, a < opnd};
         op_xori, op_xor:   alu = a ^ opnd;
         op_ori, op_or:     alu = a | opnd;
         op_andi, op_and:   alu = a & opnd;
         op_slli, op_sll:   alu = a << opnd[4:0];
         op_srli, op_srl:   alu = a >> opnd[4:0];
         op_srai, op_sra:   alu = $signed(a) >>> opnd[4:0];
         default:           alu = 32'd0;
      endcase

      // sign-magnitude mapped onto a signed line, so both zeros land on 0
      nan = (fa[30:23] == 8'hff && fa[22:0] != 23'd0) ||
            (fb[30:23] == 8'hff && fb[22:0] != 23'd0);
      key_a = fa[31] ? -$signed({2'b00, fa[30:0]}) : $signed({2'b00, fa[30:0]});
      key_b = fb[31] ? -$signed({2'b00, fb[30:0]}) : $signed({2'b00, fb[30:0]});
      case (o)
         op_fsgnj:  fpu = {fb[31], fa[30:0]};
         op_fsgnjn: fpu = {~fb[31], fa[30:0]};
         op_fsgnjx: fpu = {fa[31] ^ fb[31], fa[30:0]};
         op_feq:    fpu = {31'd0, !nan && key_a == key_b};
         op_flt:    fpu = {31'd0, !nan && key_a < key_b};
         op_fle:    fpu = {31'd0, !nan && key_a <= key_b};
         op_fmvxw:  fpu = fa;
         op_fmvwx:  fpu = a;
         default:   fpu = 32'd0;
      endcase

      e.illegal    = (o == op_illegal);
      e.mem_read   = o inside {op_lb, op_lh, op_lw, op_lbu, op_lhu, op_flw};
      e.mem_write  = o inside {op_sb, op_sh, op_sw, op_fsw};
      e.freg_write = o inside {op_flw, op_fsgnj, op_fsgnjn, op_fsgnjx, op_fmvwx};
      e.reg_write  = !e.illegal && !is_branch && !e.mem_write && !e.freg_write;
      e.write_dest = w[11:7];
      e.jump       = (o == op_jal) || (o == op_jalr) || (is_branch && alu == 32'd1);
      if (e.illegal)
         e.result = 32'd0;
      else if (o inside {op_fsgnj, op_fsgnjn, op_fsgnjx, op_feq, op_flt, op_fle,
                         op_fmvxw, op_fmvwx})
         e.result = fpu;
      else
         e.result = alu;
      if (o == op_jal || is_branch)
         e.jump_dest = p + imm;
      else if (o == op_jalr)
         e.jump_dest = (a + imm) & ~32'd1;
      else
         e.jump_dest = 32'd0;
      return e;
   endfunction

   ////////////////////
   // checks
   ////////////////////

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected)
         stop_run($sformatf("MISMATCH %s expected %08h actual %08h",
                            name, expected, actual));
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
         stop_run($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
   endtask

   task automatic check_dest(input string name, input logic [4:0] expected,
                             input logic [4:0] actual);
      if (actual !== expected)
         stop_run($sformatf("MISMATCH %s expected %0d actual %0d",
                            name, expected, actual));
   endtask

   ////////////////////
   // stimulus
   ////////////////////

   task automatic drive_instr();
      int unsigned k;
      logic [31:0] w;
      logic [31:0] p;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] fa;
      logic [31:0] fb;
      expect_t     e;
      k = $urandom_range(0, int'(op_illegal) - 1);
      if ($urandom_range(0, 31) == 0)
         w = $urandom;
      else
         w = encode_word(op_t'(k[5:0]), $urandom);
      p = $urandom;
      p[1:0] = 2'b00;
      a = $urandom;
      b = ($urandom_range(0, 3) == 0) ? a : $urandom;
      fa = float_value();
      fb = ($urandom_range(0, 3) == 0) ? fa : float_value();

      issue      <= 1'b1;
      instr_word <= w;
      pc         <= p;
      rs1_v      <= a;
      rs2_v      <= b;
      frs1_v     <= fa;
      frs2_v     <= fb;
      e = predict(w, p, a, b, fa, fb);
      // counter steps at this edge and again at the done edge
      e.due_cycle = cycles + 2;
      pending.push_back(e);
   endtask

   initial begin
      void'($urandom(32'h457e_7cbe));
      reset      <= 1'b1;
      issue      <= 1'b0;
      instr_word <= 32'd0;
      pc         <= 32'd0;
      rs1_v      <= 32'd0;
      rs2_v      <= 32'd0;
      frs1_v     <= 32'd0;
      frs2_v     <= 32'd0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      repeat (num_instr) begin
         @(posedge clk);
         drive_instr();
         repeat ($urandom_range(0, 3)) begin
            @(posedge clk);
            issue <= 1'b0;
         end
      end
      @(posedge clk);
      issue <= 1'b0;
      repeat (3) @(posedge clk);

      if (pending.size() != 0) begin
         stop_run($sformatf("%0d instructions never produced done", pending.size()));
      end else begin
         $display("TEST OK");
         $finish;
      end
   end

   // outputs settle after the rising edge
   always @(negedge clk) begin
      if (!reset && done) begin
         if (pending.size() == 0) begin
            stop_run("done was raised with no instruction outstanding");
         end else begin
            got = pending.pop_front();
            got_op = got.op;
            tag = $sformatf("instr %0d %s", checked, got_op.name());
            if (cycles != got.due_cycle)
               stop_run($sformatf("%s gave done in cycle %0d instead of cycle %0d",
                                  tag, cycles, got.due_cycle));
            check_word({tag, " result"}, got.result, result);
            check_word({tag, " jump_dest"}, got.jump_dest, jump_dest);
            check_dest({tag, " write_dest"}, got.write_dest, write_dest);
            check_flag({tag, " mem_read"}, got.mem_read, mem_read);
            check_flag({tag, " mem_write"}, got.mem_write, mem_write);
            check_flag({tag, " reg_write"}, got.reg_write, reg_write);
            check_flag({tag, " freg_write"}, got.freg_write, freg_write);
            check_flag({tag, " jump"}, got.jump, jump);
            check_flag({tag, " illegal"}, got.illegal, illegal);
            checked++;
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == cycle_limit)
         stop_run($sformatf("timeout after %0d cycles", cycles));
   end

endmodule

// ==== build.f ====
rtl/rv_exec_pkg.sv
rtl/instr_decoder.sv
rtl/int_alu.sv
rtl/float_unit.sv
rtl/execute_stage.sv
rtl/exec_top.sv
sim/exec_assertions.sv
sim/exec_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module exec_tb -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

output=$(./obj_dir/Vexec_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
   exit 0
fi
echo "pass message not found"
exit 1
